/* src/frontend_pkg.sv */
package frontend_pkg;

    localparam int xlen      = 32;
    localparam int mem_words = 256;                 // 1 KiB of instruction memory
    localparam int mem_aw    = $clog2(mem_words);   // word index width

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
    localparam logic [xlen-1:0] mem_base = reset_pc;   // sram window starts at the boot pc

    // rv32i base opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // format class
    localparam logic [2:0] fmt_r = 3'd0;
    localparam logic [2:0] fmt_i = 3'd1;
    localparam logic [2:0] fmt_s = 3'd2;
    localparam logic [2:0] fmt_b = 3'd3;
    localparam logic [2:0] fmt_u = 3'd4;
    localparam logic [2:0] fmt_j = 3'd5;

    // alu operations
    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_sll  = 4'd2;
    localparam logic [3:0] alu_slt  = 4'd3;
    localparam logic [3:0] alu_sltu = 4'd4;
    localparam logic [3:0] alu_xor  = 4'd5;
    localparam logic [3:0] alu_srl  = 4'd6;
    localparam logic [3:0] alu_sra  = 4'd7;
    localparam logic [3:0] alu_or   = 4'd8;
    localparam logic [3:0] alu_and  = 4'd9;

    // fetch fsm states
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_wait_mem = 2'd1;  // address out, data back next edge
    localparam logic [1:0] st_offer    = 2'd2;

    // one instruction word, one view per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
            logic [4:0] rd; logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
        } s;
        struct packed {
            logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
        } u;
        struct packed {
            logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
            logic [4:0] rd; logic [6:0] opcode;
        } j;
    } inst_u;

endpackage

/* src/inst_sram.sv */
`timescale 1ns/1ps

module inst_sram import frontend_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // apb slave, program load only
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [xlen-1:0] paddr,
    input  logic [xlen-1:0] pwdata,
    output logic [xlen-1:0] prdata,
    output logic            pready,
    output logic            pslverr,
    // fetch read port
    input  logic            fetch_en,
    input  logic [xlen-1:0] fetch_addr,
    output logic [xlen-1:0] fetch_data
);

    logic [xlen-1:0] mem [mem_words];

    logic              apb_setup;
    logic              apb_access;
    logic              apb_bad;
    logic [mem_aw-1:0] apb_idx;
    logic [xlen-1:0]   fetch_off;
    logic [mem_aw-1:0] fetch_idx;

    assign apb_setup  = psel & ~penable;
    assign apb_access = psel & penable;
    assign apb_idx    = paddr[mem_aw+1:2];      // paddr is a byte offset into the window
    // misaligned or past the last word
    assign apb_bad    = (paddr[1:0] != 2'b00) || (paddr[xlen-1:2] >= mem_words);

    assign pready = apb_access;     // no wait states

    // error flag and read data are set up in the setup phase,
    // so both are valid in the access phase
    always_ff @(posedge clk) begin
        if (rst) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= apb_setup & apb_bad;
        end
    end

    always_ff @(posedge clk) begin
        if (apb_setup) begin
            prdata <= apb_bad ? '0 : mem[apb_idx];  // error reads as zero
        end
    end

    // write lands at the end of the access phase
    always_ff @(posedge clk) begin
        if (apb_access && pwrite && !pslverr) begin
            mem[apb_idx] <= pwdata;
        end
    end

    assign fetch_off = fetch_addr - mem_base;
    assign fetch_idx = fetch_off[mem_aw+1:2];

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data <= mem[fetch_idx];   // one cycle read
        end
    end

    // access phase must come straight out of a setup phase
    a_apb_setup_first: assert property (
        @(posedge clk) disable iff (rst)
        (psel && penable) |-> $past(psel && !penable)
    );

endmodule

/* src/ifu.sv */
`timescale 1ns/1ps

module ifu import frontend_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    // redirects, external wins
    input  logic            jal_redir,
    input  logic [xlen-1:0] jal_target,
    input  logic            redir_en,
    input  logic [xlen-1:0] redir_pc,
    // sram fetch port
    output logic            fetch_en,
    output logic [xlen-1:0] fetch_addr,
    input  logic [xlen-1:0] fetch_data,
    // offer to decode
    output logic            if_valid,
    input  logic            if_ready,
    output logic [xlen-1:0] if_pc,
    output logic [xlen-1:0] if_inst
);

    logic [1:0]      state, nxt_state;
    logic [xlen-1:0] pc, nxt_pc;
    logic            redir;

    assign redir = redir_en | jal_redir;

    always_comb begin
        nxt_state  = state;
        nxt_pc     = pc;
        fetch_en   = 1'b0;
        fetch_addr = pc;
        if (redir) begin
            // drop whatever is held or in flight, restart at the target
            nxt_pc     = redir_en ? redir_pc : jal_target;
            fetch_addr = nxt_pc;
            fetch_en   = run;
            nxt_state  = run ? st_wait_mem : st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        fetch_en  = 1'b1;           // issue pc
                        nxt_state = st_wait_mem;
                    end
                end
                st_wait_mem: begin
                    nxt_state = st_offer;           // word captured this edge
                end
                st_offer: begin
                    if (if_ready) begin
                        nxt_pc     = pc + 32'd4;
                        fetch_addr = nxt_pc;        // next address goes out right away
                        fetch_en   = run;
                        nxt_state  = run ? st_wait_mem : st_idle;
                    end
                end
                default: nxt_state = st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            pc    <= reset_pc;
        end else begin
            state <= nxt_state;
            pc    <= nxt_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait_mem && !redir) begin
            if_inst <= fetch_data;  // sram word for pc
        end
    end

    assign if_valid = (state == st_offer);
    assign if_pc    = pc;           // pc only moves on accept or redirect

    // offered item holds until taken or flushed
    a_offer_stable: assert property (
        @(posedge clk) disable iff (rst)
        (if_valid && !if_ready && !redir) |=> ($stable(if_pc) && $stable(if_inst))
    );

endmodule

/* src/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import frontend_pkg::*; (
    input  logic [xlen-1:0] inst,
    output logic [xlen-1:0] imm
);

    inst_u w;

    assign w = inst_u'(inst);

    always_comb begin
        case (w.r.opcode)
            opc_load, opc_op_imm, opc_jalr: begin
                imm = {{20{w.i.imm[11]}}, w.i.imm};
            end
            opc_store: begin
                imm = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
            end
            opc_branch: begin
                // scattered bits back in order, bit 0 implied
                imm = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
                       w.b.imm_10_5, w.b.imm_4_1, 1'b0};
            end
            opc_lui, opc_auipc: begin
                imm = {w.u.imm_31_12, 12'b0};   // upper 20, low bits clear
            end
            opc_jal: begin
                imm = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12,
                       w.j.imm_11, w.j.imm_10_1, 1'b0};
            end
            default: imm = '0;                  // r type and unknown
        endcase
    end

endmodule

/* src/ctrl_decode.sv */
`timescale 1ns/1ps

module ctrl_decode import frontend_pkg::*; (
    input  logic [xlen-1:0] inst,
    output logic [4:0]      rd,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [2:0]      fmt,
    output logic [3:0]      alu_op,
    output logic            is_jal,
    output logic            illegal
);

    inst_u w;
    logic  alt;         // instruction bit 30, sub / sra select
    logic  f7_ok;       // funct7 is zero or 0100000
    logic [3:0] f3_op;  // alu op from funct3

    assign w     = inst_u'(inst);
    assign alt   = w.r.funct7[5];
    assign f7_ok = (w.r.funct7 == 7'b0000000) || (w.r.funct7 == 7'b0100000);

    always_comb begin
        case (w.r.funct3)
            3'b000:  f3_op = alu_add;
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b011:  f3_op = alu_sltu;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = alt ? alu_sra : alu_srl;
            3'b110:  f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
    end

    always_comb begin
        fmt     = fmt_i;
        alu_op  = alu_add;
        is_jal  = 1'b0;
        illegal = 1'b0;
        case (w.r.opcode)
            opc_op: begin
                fmt = fmt_r;
                // sub only on funct3 000, alt form only for sub and sra
                alu_op  = (w.r.funct3 == 3'b000 && alt) ? alu_sub : f3_op;
                illegal = !f7_ok || (alt && w.r.funct3 != 3'b000 && w.r.funct3 != 3'b101);
            end
            opc_op_imm: begin
                // no sub in f3_op so addi ignores bit 30
                alu_op = f3_op;
                if (w.r.funct3 == 3'b001) illegal = (w.r.funct7 != 7'b0000000);
                if (w.r.funct3 == 3'b101) illegal = !f7_ok;
            end
            opc_load, opc_jalr: fmt = fmt_i;
            opc_store:          fmt = fmt_s;
            opc_branch: begin
                fmt    = fmt_b;
                alu_op = alu_sub;   // compare by subtract
            end
            opc_lui, opc_auipc: fmt = fmt_u;
            opc_jal: begin
                fmt    = fmt_j;
                is_jal = 1'b1;
            end
            default: illegal = 1'b1;    // unknown opcode
        endcase
    end

    // fields the format does not carry read as zero
    assign rd  = (fmt == fmt_s || fmt == fmt_b) ? 5'd0 : w.r.rd;
    assign rs1 = (fmt == fmt_u || fmt == fmt_j) ? 5'd0 : w.r.rs1;
    assign rs2 = (fmt == fmt_r || fmt == fmt_s || fmt == fmt_b) ? w.r.rs2 : 5'd0;

endmodule

/* src/decode_merge.sv */
`timescale 1ns/1ps

module decode_merge import frontend_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // item from fetch plus both decode results
    input  logic            if_valid,
    output logic            if_ready,
    input  logic [xlen-1:0] if_pc,
    input  logic [xlen-1:0] if_inst,
    input  logic [xlen-1:0] imm,
    input  logic [4:0]      rd,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [2:0]      fmt,
    input  logic [3:0]      alu_op,
    input  logic            is_jal,
    input  logic            illegal,
    input  logic            redir_en,
    // jal redirect back to fetch
    output logic            jal_redir,
    output logic [xlen-1:0] jal_target,
    // output beat
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_inst,
    output logic [xlen-1:0] out_imm,
    output logic [4:0]      out_rd,
    output logic [4:0]      out_rs1,
    output logic [4:0]      out_rs2,
    output logic [2:0]      out_fmt,
    output logic [3:0]      out_alu_op,
    output logic            out_illegal
);

    logic accept;

    // room when empty or draining; nothing taken while fetch is being redirected
    assign if_ready = (!out_valid || out_ready) && !redir_en && !jal_redir;
    assign accept   = if_valid && if_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            jal_redir <= 1'b0;
        end else begin
            jal_redir <= accept && is_jal;  // one cycle pulse after the jal is latched
            if (redir_en) begin
                out_valid <= 1'b0;          // flush
            end else if (accept) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc      <= if_pc;
            out_inst    <= if_inst;
            out_imm     <= imm;
            out_rd      <= rd;
            out_rs1     <= rs1;
            out_rs2     <= rs2;
            out_fmt     <= fmt;
            out_alu_op  <= alu_op;
            out_illegal <= illegal;
        end
    end

    assign jal_target = out_pc + out_imm;   // held beat is the jal while jal_redir is up

    // a held beat stays put until out_ready or a flush
    a_beat_held: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !redir_en) |=>
            (out_valid && $stable(out_pc) && $stable(out_inst))
    );

endmodule

/* src/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    // apb program load
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [xlen-1:0] paddr,
    input  logic [xlen-1:0] pwdata,
    output logic [xlen-1:0] prdata,
    output logic            pready,
    output logic            pslverr,
    // redirect from a later stage
    input  logic            redir_en,
    input  logic [xlen-1:0] redir_pc,
    // decoded beat
    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_inst,
    output logic [xlen-1:0] out_imm,
    output logic [4:0]      out_rd,
    output logic [4:0]      out_rs1,
    output logic [4:0]      out_rs2,
    output logic [2:0]      out_fmt,
    output logic [3:0]      out_alu_op,
    output logic            out_illegal
);

    logic            fetch_en;
    logic [xlen-1:0] fetch_addr, fetch_data;
    logic            if_valid, if_ready;
    logic [xlen-1:0] if_pc, if_inst;
    logic            jal_redir;
    logic [xlen-1:0] jal_target;
    logic [xlen-1:0] imm;
    logic [4:0]      rd, rs1, rs2;
    logic [2:0]      fmt;
    logic [3:0]      alu_op;
    logic            is_jal, illegal;

    inst_sram u_inst_sram (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .fetch_en, .fetch_addr, .fetch_data
    );

    ifu u_ifu (
        .clk, .rst, .run, .jal_redir, .jal_target, .redir_en, .redir_pc,
        .fetch_en, .fetch_addr, .fetch_data, .if_valid, .if_ready, .if_pc, .if_inst
    );

    // both decoders look at the same offered word
    imm_gen u_imm_gen (.inst(if_inst), .imm);

    ctrl_decode u_ctrl_decode (
        .inst(if_inst), .rd, .rs1, .rs2, .fmt, .alu_op, .is_jal, .illegal
    );

    decode_merge u_decode_merge (
        .clk, .rst, .if_valid, .if_ready, .if_pc, .if_inst, .imm, .rd, .rs1, .rs2,
        .fmt, .alu_op, .is_jal, .illegal, .redir_en, .jal_redir, .jal_target,
        .out_valid, .out_ready, .out_pc, .out_inst, .out_imm, .out_rd, .out_rs1,
        .out_rs2, .out_fmt, .out_alu_op, .out_illegal
    );

endmodule

/* dv/frontend_model.svh */
// program image, index is the word offset from reset_pc
logic [xlen-1:0] prog [mem_words];

function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] pc);
    logic [xlen-1:0] off;
    off = pc - reset_pc;
    return prog[off[mem_aw+1:2]];   // sram index wraps past the window
endfunction

// sign extended immediate per rv32i format
function automatic logic [xlen-1:0] decoded_imm(input logic [xlen-1:0] w);
    case (w[6:0])
        opc_load, opc_op_imm, opc_jalr: return {{20{w[31]}}, w[31:20]};
        opc_store:          return {{20{w[31]}}, w[31:25], w[11:7]};
        opc_branch:         return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        opc_lui, opc_auipc: return {w[31:12], 12'h000};
        opc_jal:            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default:            return '0;     // r type, unknown
    endcase
endfunction

function automatic logic [2:0] format_class(input logic [xlen-1:0] w);
    case (w[6:0])
        opc_op:             return fmt_r;
        opc_store:          return fmt_s;
        opc_branch:         return fmt_b;
        opc_lui, opc_auipc: return fmt_u;
        opc_jal:            return fmt_j;
        default:            return fmt_i;  // load, op_imm, jalr, unknown
    endcase
endfunction

// {rd, rs1, rs2}, zero where the format has no such field
function automatic logic [14:0] reg_fields(input logic [xlen-1:0] w);
    logic [2:0] f;
    f = format_class(w);
    return {(f == fmt_s || f == fmt_b) ? 5'd0 : w[11:7],
            (f == fmt_u || f == fmt_j) ? 5'd0 : w[19:15],
            (f == fmt_r || f == fmt_s || f == fmt_b) ? w[24:20] : 5'd0};
endfunction

function automatic logic [3:0] alu_operation(input logic [xlen-1:0] w);
    if (w[6:0] == opc_branch) return alu_sub;  // compare
    if (w[6:0] != opc_op && w[6:0] != opc_op_imm) return alu_add;
    case (w[14:12])
        3'd0:    return (w[6:0] == opc_op && w[30]) ? alu_sub : alu_add;  // addi never subs
        3'd1:    return alu_sll;
        3'd2:    return alu_slt;
        3'd3:    return alu_sltu;
        3'd4:    return alu_xor;
        3'd5:    return w[30] ? alu_sra : alu_srl;
        3'd6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

function automatic logic is_illegal(input logic [xlen-1:0] w);
    logic [2:0] f3;
    logic       f7_std;     // 0000000 or 0100000
    f3     = w[14:12];
    f7_std = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
    case (w[6:0])
        opc_op:     return !f7_std || (w[30] && f3 != 3'd0 && f3 != 3'd5);
        opc_op_imm: return (f3 == 3'd1 && w[31:25] != 7'h00) || (f3 == 3'd5 && !f7_std);
        opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load, opc_store: return 1'b0;
        default:    return 1'b1;
    endcase
endfunction

// program flow, only jal leaves the sequence
function automatic logic [xlen-1:0] next_pc(input logic [xlen-1:0] pc);
    logic [xlen-1:0] w;
    w = word_at(pc);
    return (w[6:0] == opc_jal) ? pc + decoded_imm(w) : pc + 32'd4;
endfunction

/* dv/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb import frontend_pkg::*; ();

    localparam int seed         = 91;
    localparam int stream_beats = 100;
    localparam int total_beats  = 5 * stream_beats;    // streaming tests 2 to 6
    localparam int clk_period   = 40;

    logic            clk, rst, run;
    logic            psel, penable, pwrite;
    logic [xlen-1:0] paddr, pwdata, prdata;
    logic            pready, pslverr;
    logic            redir_en;
    logic [xlen-1:0] redir_pc;
    logic            out_valid, out_ready;
    logic [xlen-1:0] out_pc, out_inst, out_imm;
    logic [4:0]      out_rd, out_rs1, out_rs2;
    logic [2:0]      out_fmt;
    logic [3:0]      out_alu_op;
    logic            out_illegal;

    logic [xlen-1:0] seq_prog [mem_words];  // straight line program, tests 1 2 5 6
    logic [xlen-1:0] rd_word;               // last apb read data
    logic            rd_err;                // last apb pslverr
    int              checks, errors, tests_passed;

    `include "frontend_model.svh"

    frontend_top u_frontend_top (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // bound from the beat count, loads and bubbles fit well inside
    initial begin
        #(total_beats * 20 * clk_period);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        run = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // one two cycle apb transfer, starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;     // access phase
        #1;
        rd_word = prdata;
        rd_err  = pslverr;
        compare("pready", 32'(pready), 32'd1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_words; i++) begin
            apb_xfer(1'b1, 32'(i * 4), prog[i]);
            compare("pslverr", 32'(rd_err), 32'd0);
        end
    endtask

    // random word, jal left out since jumps are placed on purpose
    function automatic logic [31:0] random_word(input bit with_illegal);
        logic [31:0] w;
        int          pick;
        w    = $urandom;
        pick = $urandom % (with_illegal ? 9 : 8);
        case (pick)
            0: w[6:0] = opc_lui;
            1: w[6:0] = opc_auipc;
            2: w[6:0] = opc_jalr;
            3: w[6:0] = opc_branch;
            4: w[6:0] = opc_load;
            5: w[6:0] = opc_store;
            6: w[6:0] = opc_op_imm;
            7: w[6:0] = opc_op;
            default: w[6:0] = {w[6:2], 2'b01};  // low bits 01 match no opcode
        endcase
        // register ops and shifts get a standard funct7 most of the time
        if (pick == 7 || (pick == 6 && w[13:12] == 2'b01)) begin
            if (!with_illegal || $urandom % 4 != 0) begin
                w[31:25] = {1'b0, w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5), 5'd0};
            end
        end
        return w;
    endfunction

    task automatic build_program(input bit with_jal, input bit with_illegal);
        int d;
        for (int i = 0; i < mem_words; i++) begin
            prog[i] = random_word(with_illegal);
        end
        for (int i = 0; i < mem_words; i++) begin
            d = 1 + $urandom % 4;   // jump distance in words
            if (with_jal && $urandom % 6 == 0 && i + d < mem_words) begin
                prog[i] = {1'b0, 10'(d << 1), 1'b0, 8'h00, 5'($urandom), opc_jal};
            end
        end
    endtask

    task automatic check_beat(input logic [xlen-1:0] pc);
        logic [xlen-1:0] w;
        logic [14:0]     regs;
        w    = word_at(pc);
        regs = reg_fields(w);
        compare("out_pc", out_pc, pc);
        compare("out_inst", out_inst, w);
        compare("out_imm", out_imm, decoded_imm(w));
        compare("out_rd", 32'(out_rd), 32'(regs[14:10]));
        compare("out_rs1", 32'(out_rs1), 32'(regs[9:5]));
        compare("out_rs2", 32'(out_rs2), 32'(regs[4:0]));
        compare("out_fmt", 32'(out_fmt), 32'(format_class(w)));
        compare("out_alu_op", 32'(out_alu_op), 32'(alu_operation(w)));
        compare("out_illegal", 32'(out_illegal), 32'(is_illegal(w)));
    endtask

    // take n beats from reset_pc; optional random ready and one external redirect
    task automatic stream(input int n, input bit rand_ready, input int redir_cycle);
        logic [xlen-1:0] pc;    // pc the next beat must carry
        int              taken;
        bit              rdy;
        pc    = reset_pc;
        taken = 0;
        run   = 1'b1;
        for (int cyc = 0; taken < n; cyc++) begin
            @(negedge clk);
            rdy       = rand_ready ? ($urandom % 3 != 0) : 1'b1;
            out_ready = rdy;
            redir_en  = (cyc == redir_cycle);
            if (out_valid && rdy) begin     // beat leaves on the next rising edge
                check_beat(pc);
                pc = next_pc(pc);
                taken++;
            end
            if (redir_en) begin
                redir_pc = reset_pc + 32'(4 * ($urandom % 128));
                pc       = redir_pc;        // all older items are flushed
            end
        end
        @(negedge clk);
        run       = 1'b0;
        redir_en  = 1'b0;
        out_ready = 1'b1;
    endtask

    task automatic report(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
        end
    endtask

    initial begin
        int e0;
        void'($urandom(seed));
        rst = 1'b1;
        run = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        redir_en = 1'b0;
        redir_pc = '0;
        out_ready = 1'b1;
        checks = 0;
        errors = 0;
        tests_passed = 0;
        apply_reset();

        e0 = errors;
        build_program(1'b0, 1'b0);
        seq_prog = prog;
        load_program();
        for (int i = 0; i < mem_words; i++) begin
            apb_xfer(1'b0, 32'(i * 4), '0);
            compare("prdata", rd_word, prog[i]);
            compare("pslverr", 32'(rd_err), 32'd0);
        end
        apb_xfer(1'b1, 32'(mem_words * 4), 32'hdead_beef);  // one word past the end
        compare("pslverr", 32'(rd_err), 32'd1);
        apb_xfer(1'b1, 32'h0000_0012, 32'hdead_beef);       // misaligned, inside word 4
        compare("pslverr", 32'(rd_err), 32'd1);
        apb_xfer(1'b0, 32'h0000_0002, '0);                  // misaligned read gives zero
        compare("pslverr", 32'(rd_err), 32'd1);
        compare("prdata", rd_word, 32'd0);
        apb_xfer(1'b0, 32'h0000_0000, '0);
        compare("prdata", rd_word, prog[0]);
        apb_xfer(1'b0, 32'h0000_0010, '0);
        compare("prdata", rd_word, prog[4]);
        report(1, "apb load and readback", e0);

        e0 = errors;
        apply_reset();
        stream(stream_beats, 1'b0, -1);
        report(2, "sequential stream", e0);

        e0 = errors;
        build_program(1'b1, 1'b1);
        load_program();
        apply_reset();
        stream(stream_beats, 1'b0, -1);
        report(3, "decode fields", e0);

        e0 = errors;
        build_program(1'b1, 1'b0);
        load_program();
        apply_reset();
        stream(stream_beats, 1'b0, -1);
        report(4, "jal flow", e0);

        e0 = errors;
        prog = seq_prog;
        load_program();
        apply_reset();
        stream(stream_beats, 1'b1, -1);
        report(5, "back-pressure", e0);

        e0 = errors;
        apply_reset();
        stream(stream_beats, 1'b1, 10 + int'($urandom % 50));
        report(6, "external redirect", e0);

        $display("tests passed %0d of 6, checks %0d, errors %0d", tests_passed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+dv
src/frontend_pkg.sv
src/inst_sram.sv
src/ifu.sv
src/imm_gen.sv
src/ctrl_decode.sv
src/decode_merge.sv
src/frontend_top.sv
dv/frontend_tb.sv

/* run.sh */
#!/bin/sh
# build the frontend testbench with verilator, run it, grep the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
        -f compile.f -o frontend_sim \
    && ./obj_dir/frontend_sim | tee sim.log \
    && grep -qx "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
